//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regCount = 16;
	localparam int regSelWidth = 4;
	localparam int constWidth = 18; // Bit 17 of C is its sign
	localparam int opWidth = 5;

	// Low bit of each instruction field, C starts at bit 0
	localparam int opLsb = 27;
	localparam int raLsb = 23;
	localparam int rbLsb = 19;
	localparam int rcLsb = 15;

	// Encodings follow the course instruction set
	typedef enum logic [opWidth-1:0] {
		opAdd = 5'b00011,
		opSub = 5'b00100,
		opAnd = 5'b01010,
		opOr = 5'b01011,
		opAddi = 5'b01100,
		opAndi = 5'b01101,
		opOri = 5'b01110,
		opOut = 5'b10111
	} opcode_t;

	typedef enum logic [2:0] {
		stIdle,
		stT3,
		stT4,
		stT5,
		stAck // Waits for the source to drop instrReq
	} step_t;

endpackage

`default_nettype wire

//--- verilog/selectAndEncode.sv
`timescale 1ns/10ps
`default_nettype none

module selectAndEncode import cpuPkg::*; (
	input logic Gra, Grb, Grc, Rin, Rout, BAout,
	input logic [dataWidth-1:0] IRout,
	output logic [regCount-1:0] regsIn, regsOut,
	output logic [dataWidth-1:0] CSE
);

	logic [regSelWidth-1:0] raGated, rbGated, rcGated;
	logic [regSelWidth-1:0] regSel;
	logic [regCount-1:0] decoded;

	always_comb begin
		raGated = IRout[raLsb +: regSelWidth] & {regSelWidth{Gra}};
		rbGated = IRout[rbLsb +: regSelWidth] & {regSelWidth{Grb}};
		rcGated = IRout[rcLsb +: regSelWidth] & {regSelWidth{Grc}};
		// Only one of the field selects is set in any control step
		regSel = raGated | rbGated | rcGated;

		decoded = '0;
		decoded[regSel] = 1'b1;

		regsIn = Rin ? decoded : '0;
		regsOut = (Rout | BAout) ? decoded : '0; // BAout reads through the same decoder
	end

	assign CSE = {{(dataWidth - constWidth){IRout[constWidth-1]}}, IRout[constWidth-1:0]};

	// The control unit never writes and reads a register in the same step
	always_comb begin
		assert ($onehot0(regsIn) && $onehot0(regsOut) && !(|regsIn && |regsOut))
			else $error("selectAndEncode: bad register enable pattern");
	end

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile import cpuPkg::*; (
	input logic clock, rst,
	input logic [regCount-1:0] regsIn, regsOut,
	input logic BAout,
	input logic [dataWidth-1:0] bus,
	output logic [regCount*dataWidth-1:0] regValues
);

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (regsIn[i])
					regs[i] <= bus;
			end
		end
	end

	always_comb begin
		for (int i = 1; i < regCount; i++) begin
			regValues[i*dataWidth +: dataWidth] = regs[i];
		end
		// Base addressing through R0 means an address offset of zero,
		// whatever R0 itself holds
		if (BAout && regsOut[0])
			regValues[0 +: dataWidth] = '0;
		else
			regValues[0 +: dataWidth] = regs[0];
	end

	// Only the base-address step uses BAout, and it never writes back
	assert property (@(posedge clock) disable iff (rst) BAout |-> regsIn == '0)
		else $error("registerFile: write during base-address read");

endmodule

`default_nettype wire

//--- verilog/busMux.sv
`timescale 1ns/10ps
`default_nettype none

module busMux import cpuPkg::*; (
	input logic clock, rst,
	input logic [regCount-1:0] regsOut,
	input logic [regCount*dataWidth-1:0] regValues,
	input logic Rout, BAout, Zout, Cout, outPortIn,
	input logic [dataWidth-1:0] zValue, CSE,
	output logic [dataWidth-1:0] bus,
	output logic [dataWidth-1:0] outPort
);

	logic regGroup;
	logic [dataWidth-1:0] regBus;

	assign regGroup = Rout | BAout;

	always_comb begin
		regBus = '0;
		for (int i = 0; i < regCount; i++) begin
			if (regsOut[i])
				regBus = regBus | regValues[i*dataWidth +: dataWidth];
		end
	end

	// Sources are ORed, an idle bus reads as zero
	assign bus = (regGroup ? regBus : '0) | (Zout ? zValue : '0) | (Cout ? CSE : '0);

	always_ff @(posedge clock) begin
		if (rst)
			outPort <= '0;
		else if (outPortIn)
			outPort <= bus;
	end

	assert property (@(posedge clock) disable iff (rst) $onehot0({regGroup, Zout, Cout}))
		else $error("busMux: more than one bus source active");

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpuPkg::*; (
	input logic clock, rst, Yin, Zin,
	input opcode_t aluOp,
	input logic [dataWidth-1:0] bus,
	output logic [dataWidth-1:0] zValue
);

	logic [dataWidth-1:0] y;
	logic [dataWidth-1:0] result;

	// Y holds the first operand while the second one is on the bus
	always_ff @(posedge clock) begin
		if (rst)
			y <= '0;
		else if (Yin)
			y <= bus;
	end

	always_comb begin
		case (aluOp)
			opAdd, opAddi: begin
				result = y + bus;
			end
			opSub: begin
				result = y - bus; // Wraps modulo 2^32
			end
			opAnd, opAndi: begin
				result = y & bus;
			end
			opOr, opOri: begin
				result = y | bus;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst)
			zValue <= '0;
		else if (Zin)
			zValue <= result;
	end

endmodule

`default_nettype wire

//--- verilog/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit import cpuPkg::*; (
	input logic clock, rst, instrReq,
	input logic [dataWidth-1:0] instr,
	output logic instrAck, busy,
	output logic [dataWidth-1:0] IRout,
	output logic Gra, Grb, Grc, Rin, Rout, BAout, Yin, Zin, Zout, Cout, outPortIn,
	output opcode_t aluOp
);

	step_t state;
	logic regForm, immForm;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= stIdle;
			instrAck <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (instrReq)
						state <= stT3;
				end
				stT3: state <= stT4;
				stT4: state <= stT5;
				stT5: state <= stAck;
				stAck: begin
					if (!instrAck) begin
						instrAck <= 1'b1;
					end else if (!instrReq) begin
						instrAck <= 1'b0;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!rst && state == stIdle && instrReq)
			IRout <= instr;
	end

	assign aluOp = opcode_t'(IRout[opLsb +: opWidth]);
	assign busy = state != stIdle;

	always_comb begin
		regForm = aluOp inside {opAdd, opSub, opAnd, opOr};
		immForm = aluOp inside {opAddi, opAndi, opOri};

		Gra = 1'b0;
		Grb = 1'b0;
		Grc = 1'b0;
		Rin = 1'b0;
		Rout = 1'b0;
		BAout = 1'b0;
		Yin = 1'b0;
		Zin = 1'b0;
		Zout = 1'b0;
		Cout = 1'b0;
		outPortIn = 1'b0;

		case (state)
			stT3: begin
				// Rb goes to Y, through base addressing for the immediate forms
				Grb = regForm | immForm;
				Rout = regForm;
				BAout = immForm;
				Yin = regForm | immForm;
				if (aluOp == opOut) begin
					Gra = 1'b1;
					Rout = 1'b1;
					outPortIn = 1'b1;
				end
			end
			stT4: begin
				Grc = regForm;
				Rout = regForm;
				Cout = immForm;
				Zin = regForm | immForm;
			end
			stT5: begin
				Zout = regForm | immForm; // Write the result back to Ra
				Gra = regForm | immForm;
				Rin = regForm | immForm;
			end
			default: begin
			end
		endcase
	end

	assert property (@(posedge clock) disable iff (rst) $rose(instrAck) |-> state == stAck)
		else $error("controlUnit: instrAck rose outside stAck");

endmodule

`default_nettype wire

//--- verilog/datapathTop.sv
`timescale 1ns/10ps
`default_nettype none

module datapathTop import cpuPkg::*; (
	input logic clock, rst,
	input logic instrReq,
	input logic [dataWidth-1:0] instr,
	output logic instrAck, busy,
	output logic [dataWidth-1:0] outPort
);

	logic [dataWidth-1:0] IRout, CSE, bus, zValue;
	logic Gra, Grb, Grc, Rin, Rout, BAout;
	logic Yin, Zin, Zout, Cout, outPortIn;
	opcode_t aluOp;
	logic [regCount-1:0] regsIn, regsOut;
	logic [regCount*dataWidth-1:0] regValues;

	controlUnit controlUnit_inst (
		.clock(clock), .rst(rst), .instrReq(instrReq), .instr(instr),
		.instrAck(instrAck), .busy(busy), .IRout(IRout),
		.Gra(Gra), .Grb(Grb), .Grc(Grc), .Rin(Rin), .Rout(Rout), .BAout(BAout),
		.Yin(Yin), .Zin(Zin), .Zout(Zout), .Cout(Cout), .outPortIn(outPortIn),
		.aluOp(aluOp)
	);

	selectAndEncode selectAndEncode_inst (
		.Gra(Gra), .Grb(Grb), .Grc(Grc), .Rin(Rin), .Rout(Rout), .BAout(BAout),
		.IRout(IRout),
		.regsIn(regsIn), .regsOut(regsOut),
		.CSE(CSE)
	);

	registerFile registerFile_inst (
		.clock(clock), .rst(rst),
		.regsIn(regsIn), .regsOut(regsOut),
		.BAout(BAout),
		.bus(bus),
		.regValues(regValues)
	);

	busMux busMux_inst (
		.clock(clock), .rst(rst),
		.regsOut(regsOut), .regValues(regValues),
		.Rout(Rout), .BAout(BAout), .Zout(Zout), .Cout(Cout), .outPortIn(outPortIn),
		.zValue(zValue), .CSE(CSE),
		.bus(bus),
		.outPort(outPort)
	);

	alu alu_inst (
		.clock(clock), .rst(rst), .Yin(Yin), .Zin(Zin),
		.aluOp(aluOp),
		.bus(bus),
		.zValue(zValue)
	);

endmodule

`default_nettype wire

//--- bench/datapathBench.sv
`timescale 1ns/10ps
`default_nettype none

module datapathBench import cpuPkg::*; ();

	localparam int resetCycles = 16;
	localparam int randomRows = 40;
	localparam int ackLatency = 5; // IR load edge, then T3, T4, T5 and the ack edge
	localparam logic [31:0] lfsrSeed = 32'ha23e5259;
	localparam logic [31:0] lfsrTaps = 32'h80200003;

	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic check; // Compare outPort with the model after this row
		logic [3:0] hold; // Extra cycles with instrReq held after the ack
	} row_t;

	logic clock = 1'b0;
	logic rst;
	logic instrReq;
	logic [dataWidth-1:0] instr;
	logic instrAck, busy;
	logic [dataWidth-1:0] outPort;

	row_t rows[$];
	row_t row;
	logic [dataWidth-1:0] modelRegs [regCount];
	logic [dataWidth-1:0] modelOut;
	logic [31:0] lfsrState;
	int cycles = 0;
	int cycleLimit = 0;
	opcode_t opList [8] = '{opAdd, opSub, opAnd, opOr, opAddi, opAndi, opOri, opOut};

	datapathTop datapathTop_inst (
		.clock(clock), .rst(rst),
		.instrReq(instrReq), .instr(instr),
		.instrAck(instrAck), .busy(busy),
		.outPort(outPort)
	);

	always #50 clock = ~clock;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycleLimit != 0 && cycles >= cycleLimit)
			abortRun($sformatf("Timeout: the instruction sequence did not finish in %0d cycles",
				cycleLimit));
	end

	task automatic checkOutPort(input logic [dataWidth-1:0] actual, expected, input string what);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0t: %s, outPort %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic checkIdle(input logic ack, busyNow, input string what);
		if (ack !== 1'b0 || busyNow !== 1'b0)
			abortRun($sformatf("Fail at %0t: %s, instrAck %b busy %b, expected both low",
				$time, what, ack, busyNow));
	endtask

	task automatic checkHeld(input logic ack, busyNow, input string what);
		if (ack !== 1'b1 || busyNow !== 1'b1)
			abortRun($sformatf("Fail at %0t: %s, instrAck %b busy %b, expected both high",
				$time, what, ack, busyNow));
	endtask

	task automatic checkLatency(input int waited, input logic [dataWidth-1:0] word);
		if (waited != ackLatency)
			abortRun($sformatf("Fail at %0t: instrAck for %h after %0d cycles, expected %0d",
				$time, word, waited, ackLatency));
	endtask

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ lfsrTaps) : (state >> 1);
	endfunction

	task automatic takeBits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	function automatic logic [31:0] regOp(input opcode_t op, input logic [3:0] ra, rb, rc);
		return {op, ra, rb, rc, 15'd0};
	endfunction

	function automatic logic [31:0] immOp(input opcode_t op, input logic [3:0] ra, rb,
		input logic [17:0] c);
		return {op, ra, rb, 1'b0, c};
	endfunction

	function automatic logic [31:0] outOp(input logic [3:0] ra);
		return {opOut, ra, 23'd0};
	endfunction

	task automatic addRow(input logic [31:0] word, input logic check, input logic [3:0] hold);
		row_t entry;
		entry.instr = word;
		entry.check = check;
		entry.hold = hold;
		rows.push_back(entry);
	endtask

	// Reference model, fields as in the instruction format
	task automatic applyModel(input logic [31:0] word);
		opcode_t op;
		logic [3:0] ra, rb, rc;
		logic [31:0] c, base;
		op = opcode_t'(word[31:27]);
		ra = word[26:23];
		rb = word[22:19];
		rc = word[18:15];
		c = {{14{word[17]}}, word[17:0]};
		base = (rb == 4'd0) ? 32'd0 : modelRegs[rb]; // Base addressing reads R0 as zero
		case (op)
			opAdd: modelRegs[ra] = modelRegs[rb] + modelRegs[rc];
			opSub: modelRegs[ra] = modelRegs[rb] - modelRegs[rc];
			opAnd: modelRegs[ra] = modelRegs[rb] & modelRegs[rc];
			opOr: modelRegs[ra] = modelRegs[rb] | modelRegs[rc];
			opAddi: modelRegs[ra] = base + c;
			opAndi: modelRegs[ra] = base & c;
			opOri: modelRegs[ra] = base | c;
			opOut: modelOut = modelRegs[ra];
			default: begin
			end
		endcase
	endtask

	task automatic fillTable();
		addRow(outOp(4'd5), 1'b1, 4'd0); // Registers read zero after reset
		addRow(outOp(4'd0), 1'b1, 4'd0);
		addRow(immOp(opAddi, 4'd1, 4'd0, 18'd100), 1'b0, 4'd0);
		addRow(immOp(opAddi, 4'd2, 4'd0, 18'h3fffb), 1'b0, 4'd0);
		addRow(outOp(4'd1), 1'b1, 4'd0);
		addRow(outOp(4'd2), 1'b1, 4'd0);
		// R0 now holds a value, base addressing still has to read zero
		addRow(immOp(opAddi, 4'd0, 4'd0, 18'h01234), 1'b0, 4'd0);
		addRow(outOp(4'd0), 1'b1, 4'd0);
		addRow(immOp(opAddi, 4'd3, 4'd0, 18'd7), 1'b0, 4'd0);
		addRow(outOp(4'd3), 1'b1, 4'd0);
		addRow(immOp(opAddi, 4'd4, 4'd0, 18'h1ffff), 1'b0, 4'd0);
		addRow(immOp(opAddi, 4'd5, 4'd0, 18'h20000), 1'b0, 4'd0);
		addRow(outOp(4'd4), 1'b1, 4'd0);
		addRow(outOp(4'd5), 1'b1, 4'd0);
		addRow(regOp(opAdd, 4'd6, 4'd1, 4'd2), 1'b0, 4'd0);
		addRow(outOp(4'd6), 1'b1, 4'd0);
		addRow(regOp(opSub, 4'd7, 4'd3, 4'd1), 1'b0, 4'd0); // Wraps below zero
		addRow(outOp(4'd7), 1'b1, 4'd0);
		addRow(regOp(opAnd, 4'd8, 4'd2, 4'd4), 1'b0, 4'd0);
		addRow(outOp(4'd8), 1'b1, 4'd0);
		addRow(regOp(opOr, 4'd9, 4'd1, 4'd5), 1'b0, 4'd0);
		addRow(outOp(4'd9), 1'b1, 4'd0);
		addRow(regOp(opAdd, 4'd10, 4'd0, 4'd3), 1'b0, 4'd0); // Plain Rout sees the stored R0
		addRow(outOp(4'd10), 1'b1, 4'd0);
		addRow(immOp(opAndi, 4'd11, 4'd2, 18'h00ff0), 1'b0, 4'd0);
		addRow(outOp(4'd11), 1'b1, 4'd0);
		addRow(immOp(opOri, 4'd12, 4'd1, 18'h30000), 1'b0, 4'd0);
		addRow(outOp(4'd12), 1'b1, 4'd0);
		addRow(immOp(opAndi, 4'd13, 4'd5, 18'h2f00f), 1'b0, 4'd0);
		addRow(outOp(4'd13), 1'b1, 4'd0);
		// The source keeps instrReq up well past the ack
		addRow(immOp(opAddi, 4'd14, 4'd0, 18'd42), 1'b0, 4'd6);
		addRow(outOp(4'd14), 1'b1, 4'd3);
		addRow(regOp(opSub, 4'd15, 4'd14, 4'd14), 1'b0, 4'd0);
		addRow(outOp(4'd15), 1'b1, 4'd0);
	endtask

	task automatic randomRow(output row_t entry);
		logic [31:0] opSel, ra, rb, tail;
		opcode_t op;
		takeBits(4, opSel);
		takeBits(4, ra);
		takeBits(4, rb);
		takeBits(19, tail);
		op = opSel[3] ? opOut : opList[opSel[2:0]]; // Half the draws are out, to observe often
		entry.instr = {op, ra[3:0], rb[3:0], tail[18:0]};
		entry.check = (op == opOut);
		entry.hold = 4'd0;
	endtask

	// Starts and ends on a falling edge
	task automatic runInstruction(input row_t entry);
		int waited;
		waited = 0;
		applyModel(entry.instr);
		instr = entry.instr;
		instrReq = 1'b1;
		do begin
			@(negedge clock);
			waited++;
		end while (!instrAck);
		checkLatency(waited, entry.instr);
		repeat (entry.hold) begin
			@(negedge clock);
			checkHeld(instrAck, busy, "request held after ack");
			checkOutPort(outPort, modelOut, "outPort moved while ack held");
		end
		if (entry.check)
			checkOutPort(outPort, modelOut, $sformatf("out instruction %h", entry.instr));
		instrReq = 1'b0;
		do begin
			@(negedge clock);
		end while (instrAck);
		checkIdle(instrAck, busy, "after ack fell");
	endtask

	initial begin
		rst = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		lfsrState = lfsrSeed;
		modelOut = '0;
		for (int i = 0; i < regCount; i++) begin
			modelRegs[i] = '0;
		end
		fillTable();
		cycleLimit = (rows.size() + randomRows) * 12 + resetCycles;

		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		checkIdle(instrAck, busy, "after reset");
		checkOutPort(outPort, '0, "after reset");

		foreach (rows[i]) begin
			runInstruction(rows[i]);
		end
		for (int n = 0; n < randomRows; n++) begin
			randomRow(row);
			runInstruction(row);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/cpuPkg.sv
verilog/selectAndEncode.sv
verilog/registerFile.sv
verilog/busMux.sv
verilog/alu.sv
verilog/controlUnit.sv
verilog/datapathTop.sv
bench/datapathBench.sv

//--- Makefile
# Verilator build of the datapath testbench
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module datapathBench -Mdir $(BUILD) -o datapathBench -f list.f

run: compile
	./$(BUILD)/datapathBench

clean:
	rm -rf $(BUILD)
